// ==== filelist.f ====
cu_isa_pkg.sv
cu_ctrl_pkg.sv
cu_ifs.sv
cycle_sequencer.sv
cex_tracker.sv
cond_eval.sv
exec_ctrl.sv
control_unit.sv
tb_clock_gen.sv
tb_control_unit.sv

// ==== Bender.yml ====
package:
  name: cpu_control_unit

sources:
  - files:
      - cu_isa_pkg.sv
      - cu_ctrl_pkg.sv
      - cu_ifs.sv
      - cycle_sequencer.sv
      - cex_tracker.sv
      - cond_eval.sv
      - exec_ctrl.sv
      - control_unit.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_control_unit.sv

// ==== tb_control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_control_unit;

	localparam int TIMEOUT_CYCLES = 2000;	// About four times the worst case of ~530 cycles
	localparam logic [31:0] LFSR_SEED = 32'h75c2;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;	// x^32 + x^22 + x^2 + x + 1
	localparam logic [15:0] PC_VALUE = 16'h0200;
	localparam logic [15:0] BRK_AWAY = 16'h0ffe;	// Never equal to the PC
	localparam logic [6:0] IDLE_WORD = 7'h7f;
	localparam logic [6:0] PC_TO_MAR = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_MDR};
	localparam logic [6:0] ALU_TO_REG = {1'b0, cu_ctrl_pkg::SRC_ALU, cu_ctrl_pkg::DST_REG};
	localparam logic [6:0] MDR_TO_IR = {1'b0, cu_ctrl_pkg::SRC_MDR, cu_ctrl_pkg::DST_IR};
	localparam logic [6:0] REG_TO_REG = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG};

	logic clock;
	logic cpucycle_rst;
	logic [15:0] pc;
	logic [15:0] brkpnt;
	logic [6:0] op;
	logic [2:0] dst;
	logic [2:0] srccon;
	logic rc;
	logic wb;
	logic [3:0] cond;
	logic [2:0] t_cnt;
	logic [2:0] f_cnt;
	logic [4:0] pswb;
	logic [15:0] psw_in;
	logic step_done;
	logic [6:0] data_bus_ctrl;
	logic [6:0] addr_bus_ctrl;
	logic [1:0] psw_bus_ctrl;
	logic psw_update;
	logic [5:0] alu_op;
	logic [4:0] dbus_rnum_dst;
	logic [4:0] dbus_rnum_src;
	logic [4:0] alu_rnum_dst;
	logic [4:0] alu_rnum_src;
	logic [4:0] addr_rnum_src;
	logic s_bus_ctrl;
	logic sxt_bus_ctrl;
	logic sxt_shift;
	logic [4:0] sxt_bit_num;
	logic [15:0] psw_out;
	logic id_en;
	logic [3:0] cycle;
	logic [7:0] cex_state_out;
	logic [31:0] lfsr_state;
	int cycle_count = 0;

	tb_clock_gen u_clk
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst)
	);

	control_unit u_dut (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_val(input string test, input string what, input logic [15:0] exp,
		input logic [15:0] got);
		assert (got === exp)
		else
			stop_run($sformatf("mismatch %s %s expected %h actual %h", test, what, exp, got));
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			stop_run("timeout, the tests did not finish within the cycle limit");
	end

	// One LFSR step per bit taken, newest bit in the LSB
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int i;
		val = '0;
		for (i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
		end
		return val;
	endfunction

	// Reference model of the 15 condition codes
	function automatic logic cond_holds(input logic [3:0] code, input logic [4:0] flags);
		logic c;
		logic z;
		logic n;
		logic v;
		c = flags[0];
		z = flags[1];
		n = flags[2];
		v = flags[4];	// Bit 3 is sleep
		case (code)
			4'd0: return z;
			4'd1: return !z;
			4'd2: return c;
			4'd3: return !c;
			4'd4: return n;
			4'd5: return !n;
			4'd6: return v;
			4'd7: return !v;
			4'd8: return c && !z;
			4'd9: return !c || z;
			4'd10: return n == v;
			4'd11: return n != v;
			4'd12: return !z && (n == v);
			4'd13: return z || (n != v);
			4'd14: return 1'b1;
			default: return 1'b0;	// Code 15
		endcase
	endfunction

	function automatic logic [3:0] branch_code(input logic [6:0] br_op);
		case (br_op)
			7'd1: return 4'd0;	// BEQ
			7'd2: return 4'd1;	// BNE
			7'd3: return 4'd2;	// BC
			7'd4: return 4'd3;	// BNC
			7'd5: return 4'd4;	// BN
			7'd6: return 4'd10;	// BGE
			7'd7: return 4'd11;	// BLT
			default: return 4'd14;	// BRA always taken
		endcase
	endfunction

	task automatic check_fetch(input string test);
		check_val(test, "fetch cycle", 16'd1, cycle);
		check_val(test, "fetch addr bus", PC_TO_MAR, addr_bus_ctrl);
		check_val(test, "fetch addr reg", 16'd7, addr_rnum_src);
		check_val(test, "fetch alu op", 16'd0, alu_op);
		check_val(test, "fetch alu const", 16'd10, alu_rnum_src);	// PC plus constant 2
	endtask

	// From FETCH to EXEC1, or to the next FETCH when decode is refused
	task automatic front_end(input string test, input logic allow);
		@(negedge clock);
		check_val(test, "pc_wb cycle", 16'd2, cycle);
		check_val(test, "pc_wb data bus", ALU_TO_REG, data_bus_ctrl);
		@(negedge clock);
		check_val(test, "ir_load cycle", 16'd3, cycle);
		check_val(test, "ir_load data bus", MDR_TO_IR, data_bus_ctrl);
		@(negedge clock);
		check_val(test, "decode cycle", 16'd4, cycle);
		check_val(test, "decode id_en", allow, id_en);
		@(negedge clock);
		check_val(test, "after decode cycle", allow ? 16'd5 : 16'd1, cycle);
	endtask

	task automatic expect_end(input string test);
		@(negedge clock);
		check_val(test, "next cycle", 16'd1, cycle);	// No halt cause present
	endtask

	task automatic run_mov(input string test, input logic allow);
		logic [31:0] rnd;
		check_fetch(test);
		rnd = rand_bits(7);
		op = cu_isa_pkg::OP_MOV;
		dst = rnd[2:0];
		srccon = rnd[5:3];
		wb = rnd[6];
		rc = 1'b0;
		front_end(test, allow);
		if (allow)
		begin
			check_val(test, "data bus", {wb, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG},
				data_bus_ctrl);
			check_val(test, "dbus src", srccon, dbus_rnum_src);
			check_val(test, "dbus dst", dst, dbus_rnum_dst);
			check_val(test, "psw_update", 16'd0, psw_update);
			check_val(test, "step_done", 16'd1, step_done);
		end
	endtask

	task automatic test_reset();
		@(posedge clock);
		@(negedge clock);
		check_val("reset", "cycle", 16'd0, cycle);
		check_val("reset", "data bus", IDLE_WORD, data_bus_ctrl);
		check_val("reset", "addr bus", IDLE_WORD, addr_bus_ctrl);
		check_val("reset", "psw select", 16'd3, psw_bus_ctrl);
		check_val("reset", "id_en", 16'd0, id_en);
		check_val("reset", "psw_update", 16'd0, psw_update);
		check_val("reset", "cex active", 16'd0, cex_state_out[7]);
		check_val("reset", "psw_out", 16'd0, psw_out);
		while (cpucycle_rst)
			@(negedge clock);
		check_val("reset", "cycle after release", 16'd0, cycle);
		@(negedge clock);
		check_val("reset", "leave halt", 16'd1, cycle);
	endtask

	task automatic test_alu_ops(input int count);
		logic [31:0] rnd;
		logic [3:0] pick;
		logic [5:0] exp_op;
		repeat (count)
		begin
			check_fetch("alu");
			pick = 4'(rand_bits(4) % 14);
			rnd = rand_bits(8);
			op = (pick < 4'd12) ? 7'(9 + pick) : 7'(23 + pick - 12);	// ADD..BIS, SRA, RRC
			dst = rnd[2:0];
			srccon = rnd[5:3];
			rc = rnd[6];
			wb = rnd[7];
			if ((op == cu_isa_pkg::OP_SRA) || (op == cu_isa_pkg::OP_RRC))
				exp_op = 6'(2 * (int'(op) - 11) + int'(wb));
			else
				exp_op = 6'(2 * (int'(op) - 9) + int'(wb));
			front_end("alu", 1'b1);
			check_val("alu", "alu op", exp_op, alu_op);
			check_val("alu", "alu dst", dst, alu_rnum_dst);
			check_val("alu", "alu src", 16'(srccon) + (rc ? 16'd8 : 16'd0), alu_rnum_src);
			check_val("alu", "dbus dst", dst, dbus_rnum_dst);
			check_val("alu", "data bus", {wb, cu_ctrl_pkg::SRC_ALU, cu_ctrl_pkg::DST_REG},
				data_bus_ctrl);
			check_val("alu", "psw_update", 16'd1, psw_update);
			check_val("alu", "psw select", 16'd0, psw_bus_ctrl);
			check_val("alu", "step_done", 16'd1, step_done);
			expect_end("alu");
		end
	endtask

	task automatic test_mov(input int count);
		repeat (count)
		begin
			run_mov("mov", 1'b1);
			expect_end("mov");
		end
	endtask

	task automatic test_branches(input int rounds);
		logic [4:0] flags;
		logic taken;
		int b;
		for (b = 1; b <= 8; b++)
		begin
			repeat (rounds)
			begin
				check_fetch("branch");
				flags = 5'(rand_bits(5)) & 5'b10111;	// Sleep kept clear
				taken = cond_holds(branch_code(7'(b)), flags);
				op = 7'(b);
				psw_in = {11'd0, flags};
				front_end("branch", 1'b1);
				check_val("branch", "data bus", taken ? ALU_TO_REG : IDLE_WORD, data_bus_ctrl);
				check_val("branch", "s bus", taken, s_bus_ctrl);	// Offset onto the S-bus
				check_val("branch", "sxt bus", taken, sxt_bus_ctrl);
				check_val("branch", "sxt shift", taken, sxt_shift);
				check_val("branch", "step_done", 16'd1, step_done);
				if (taken)
					check_val("branch", "sxt bit", 16'd10, sxt_bit_num);
				expect_end("branch");
			end
		end
		psw_in = '0;
	endtask

	task automatic test_swap(input int count);
		logic [31:0] rnd;
		repeat (count)
		begin
			check_fetch("swap");
			rnd = rand_bits(6);
			op = cu_isa_pkg::OP_SWAP;
			dst = rnd[2:0];
			srccon = rnd[5:3];
			front_end("swap", 1'b1);
			check_val("swap", "exec1 src", srccon, dbus_rnum_src);
			check_val("swap", "exec1 dst", 16'd16, dbus_rnum_dst);	// Into TEMP
			check_val("swap", "exec1 bus", REG_TO_REG, data_bus_ctrl);
			check_val("swap", "exec1 step_done", 16'd0, step_done);
			@(negedge clock);
			check_val("swap", "exec2 cycle", 16'd6, cycle);
			check_val("swap", "exec2 src", dst, dbus_rnum_src);
			check_val("swap", "exec2 dst", srccon, dbus_rnum_dst);
			check_val("swap", "exec2 bus", REG_TO_REG, data_bus_ctrl);
			check_val("swap", "exec2 step_done", 16'd0, step_done);
			@(negedge clock);
			check_val("swap", "exec3 cycle", 16'd7, cycle);
			check_val("swap", "exec3 src", 16'd16, dbus_rnum_src);	// Out of TEMP
			check_val("swap", "exec3 dst", dst, dbus_rnum_dst);
			check_val("swap", "exec3 bus", REG_TO_REG, data_bus_ctrl);
			check_val("swap", "exec3 step_done", 16'd1, step_done);
			expect_end("swap");
		end
	endtask

	task automatic test_flag_ops(input int count);
		logic [31:0] rnd;
		logic [15:0] psw_val;
		logic [15:0] exp_psw;
		int k;
		for (k = 0; k < count; k++)
		begin
			check_fetch("flags");
			rnd = rand_bits(21);
			psw_val = {rnd[15:5], rnd[4:0] & 5'b10111};
			op = k[0] ? cu_isa_pkg::OP_CLRCC : cu_isa_pkg::OP_SETCC;
			pswb = rnd[20:16];
			psw_in = psw_val;
			if (k[0])
				exp_psw = {psw_val[15:5], psw_val[4:0] & ~pswb};
			else
				exp_psw = {psw_val[15:5], psw_val[4:0] | pswb};
			front_end("flags", 1'b1);
			check_val("flags", "psw follows", psw_val, psw_out);
			expect_end("flags");
			check_val("flags", "psw after op", exp_psw, psw_out);
		end
		psw_in = '0;
		pswb = '0;
	endtask

	task automatic test_cex(input int blocks);
		logic [3:0] code;
		logic [4:0] flags;
		logic res;
		logic active;
		logic allow;
		logic [2:0] mt;
		logic [2:0] mf;
		repeat (blocks)
		begin
			check_fetch("cex");
			code = 4'(rand_bits(4) % 15);
			flags = 5'(rand_bits(5)) & 5'b10111;
			mt = 3'(rand_bits(3));
			mf = 3'(rand_bits(3));
			res = cond_holds(code, flags);
			op = cu_isa_pkg::OP_CEX;
			cond = code;
			t_cnt = mt;
			f_cnt = mf;
			psw_in = {11'd0, flags};
			front_end("cex", 1'b1);
			check_val("cex", "data bus", IDLE_WORD, data_bus_ctrl);
			expect_end("cex");
			check_val("cex", "loaded state", {8'd0, 1'b1, res, mt, mf}, cex_state_out);
			active = 1'b1;
			while (active)
			begin
				allow = (res && (mt != 3'd0)) || (!res && (mt == 3'd0) && (mf != 3'd0));
				run_mov("cex block", allow);
				if (allow)
					expect_end("cex block");
				if (mt != 3'd0)
					mt = mt - 3'd1;	// True part is used up first
				else if (mf != 3'd0)
					mf = mf - 3'd1;
				active = (mt != 3'd0) || (mf != 3'd0);
			end
			check_val("cex", "block done", 16'd0, cex_state_out[7]);
		end
		psw_in = '0;
	endtask

	task automatic hold_halt(input string test);
		@(negedge clock);
		check_val(test, "enter halt", 16'd0, cycle);
		repeat (4)
		begin
			@(negedge clock);
			check_val(test, "hold halt", 16'd0, cycle);
		end
	endtask

	task automatic test_halt();
		brkpnt = PC_VALUE;	// Breakpoint hit at the end of this MOV
		run_mov("halt brk", 1'b1);
		hold_halt("halt brk");
		brkpnt = BRK_AWAY;
		@(negedge clock);
		check_val("halt brk", "resume", 16'd1, cycle);
		psw_in = 16'h0008;	// Sleep bit
		run_mov("halt sleep", 1'b1);
		hold_halt("halt sleep");
		psw_in = '0;
		@(negedge clock);
		check_val("halt sleep", "resume", 16'd1, cycle);
	endtask

	initial
	begin
		lfsr_state = LFSR_SEED;
		pc = PC_VALUE;
		brkpnt = BRK_AWAY;
		op = '0;
		dst = '0;
		srccon = '0;
		rc = 1'b0;
		wb = 1'b0;
		cond = '0;
		t_cnt = '0;
		f_cnt = '0;
		pswb = '0;
		psw_in = '0;
		test_reset();
		test_alu_ops(16);
		test_mov(6);
		test_branches(3);
		test_swap(3);
		test_flag_ops(4);
		test_cex(3);
		test_halt();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
	output logic clock,
	output logic cpucycle_rst
);

	localparam int HALF_PERIOD = 2;	// 4 ns period
	localparam int RESET_CYCLES = 8;

	initial
	begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial
	begin
		cpucycle_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		cpucycle_rst <= 1'b0;	// Low from the ninth rising edge on
	end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit
(
	input logic clock,
	input logic cpucycle_rst,
	input cu_isa_pkg::word_t pc,
	input cu_isa_pkg::word_t brkpnt,
	input cu_isa_pkg::opcode_t op,
	input cu_isa_pkg::reg_sel_t dst,
	input cu_isa_pkg::reg_sel_t srccon,
	input logic rc,
	input logic wb,
	input cu_isa_pkg::cond_t cond,
	input cu_isa_pkg::cex_cnt_t t_cnt,
	input cu_isa_pkg::cex_cnt_t f_cnt,
	input cu_isa_pkg::flag_bits_t pswb,
	input cu_isa_pkg::word_t psw_in,
	output logic step_done,
	output cu_ctrl_pkg::bus_ctrl_t data_bus_ctrl,
	output cu_ctrl_pkg::bus_ctrl_t addr_bus_ctrl,
	output cu_ctrl_pkg::psw_sel_t psw_bus_ctrl,
	output logic psw_update,
	output cu_ctrl_pkg::alu_op_t alu_op,
	output cu_isa_pkg::rnum_t dbus_rnum_dst,
	output cu_isa_pkg::rnum_t dbus_rnum_src,
	output cu_isa_pkg::rnum_t alu_rnum_dst,
	output cu_isa_pkg::rnum_t alu_rnum_src,
	output cu_isa_pkg::rnum_t addr_rnum_src,
	output logic s_bus_ctrl,
	output logic sxt_bus_ctrl,
	output logic sxt_shift,
	output logic [4:0] sxt_bit_num,
	output cu_isa_pkg::word_t psw_out,
	output logic id_en,
	output logic [3:0] cycle,
	output logic [7:0] cex_state_out
);

	cu_ctrl_pkg::cycle_state_t state;
	logic decode_allow;

	instr_if u_instr ();
	cex_load_if u_cex_load ();

	assign u_instr.op = op;	// Decoder fields straight from the ID
	assign u_instr.dst = dst;
	assign u_instr.srccon = srccon;
	assign u_instr.rc = rc;
	assign u_instr.wb = wb;
	assign u_instr.cond = cond;
	assign u_instr.t_cnt = t_cnt;
	assign u_instr.f_cnt = f_cnt;
	assign u_instr.pswb = pswb;

	assign cycle = {1'b0, state};	// Cycle number for the datapath

	cycle_sequencer u_seq
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.pc(pc),
		.brkpnt(brkpnt),
		.psw_in(psw_in),
		.step_done(step_done),
		.decode_allow(decode_allow),
		.state(state),
		.id_en(id_en)
	);

	cex_tracker u_cex
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.state(state),
		.cex_load(u_cex_load.dst_mp),
		.decode_allow(decode_allow),
		.cex_state(cex_state_out)
	);

	exec_ctrl u_exec
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.state(state),
		.instr(u_instr.exec_mp),
		.psw_in(psw_in),
		.cex_load(u_cex_load.src_mp),
		.step_done(step_done),
		.data_bus_ctrl(data_bus_ctrl),
		.addr_bus_ctrl(addr_bus_ctrl),
		.psw_bus_ctrl(psw_bus_ctrl),
		.psw_update(psw_update),
		.alu_op(alu_op),
		.dbus_rnum_dst(dbus_rnum_dst),
		.dbus_rnum_src(dbus_rnum_src),
		.alu_rnum_dst(alu_rnum_dst),
		.alu_rnum_src(alu_rnum_src),
		.addr_rnum_src(addr_rnum_src),
		.s_bus_ctrl(s_bus_ctrl),
		.sxt_bus_ctrl(sxt_bus_ctrl),
		.sxt_shift(sxt_shift),
		.sxt_bit_num(sxt_bit_num),
		.psw_out(psw_out)
	);

endmodule

`default_nettype wire

// ==== exec_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_ctrl
(
	input logic clock,
	input logic cpucycle_rst,
	input cu_ctrl_pkg::cycle_state_t state,
	instr_if.exec_mp instr,
	input cu_isa_pkg::word_t psw_in,
	cex_load_if.src_mp cex_load,
	output logic step_done,
	output cu_ctrl_pkg::bus_ctrl_t data_bus_ctrl,
	output cu_ctrl_pkg::bus_ctrl_t addr_bus_ctrl,
	output cu_ctrl_pkg::psw_sel_t psw_bus_ctrl,
	output logic psw_update,
	output cu_ctrl_pkg::alu_op_t alu_op,
	output cu_isa_pkg::rnum_t dbus_rnum_dst,
	output cu_isa_pkg::rnum_t dbus_rnum_src,
	output cu_isa_pkg::rnum_t alu_rnum_dst,
	output cu_isa_pkg::rnum_t alu_rnum_src,
	output cu_isa_pkg::rnum_t addr_rnum_src,
	output logic s_bus_ctrl,
	output logic sxt_bus_ctrl,
	output logic sxt_shift,
	output logic [4:0] sxt_bit_num,
	output cu_isa_pkg::word_t psw_out
);

	cu_isa_pkg::cond_t sel_code;	// Condition for branch or CEX
	logic taken;
	logic is_shift;
	logic [4:0] alu_idx;
	cu_isa_pkg::rnum_t dst_rnum;
	cu_isa_pkg::rnum_t src_rnum;
	cu_isa_pkg::rnum_t src_rc_rnum;
	cu_isa_pkg::flag_bits_t flags_nxt;

	always_comb
	begin
		case (instr.op)
			cu_isa_pkg::OP_BEQ: sel_code = cu_isa_pkg::COND_EQ;
			cu_isa_pkg::OP_BNE: sel_code = cu_isa_pkg::COND_NE;
			cu_isa_pkg::OP_BC: sel_code = cu_isa_pkg::COND_CS;
			cu_isa_pkg::OP_BNC: sel_code = cu_isa_pkg::COND_CC;
			cu_isa_pkg::OP_BN: sel_code = cu_isa_pkg::COND_MI;
			cu_isa_pkg::OP_BGE: sel_code = cu_isa_pkg::COND_GE;
			cu_isa_pkg::OP_BLT: sel_code = cu_isa_pkg::COND_LT;
			cu_isa_pkg::OP_BRA: sel_code = cu_isa_pkg::COND_AL;
			default: sel_code = instr.cond;	// CEX carries its own code
		endcase
	end

	cond_eval u_cond
	(
		.cond(sel_code),
		.flags(psw_in[4:0]),
		.taken(taken)
	);

	// SRA and RRC continue the ALU numbering after BIS, skipping MOV and SWAP
	assign is_shift = (instr.op == cu_isa_pkg::OP_SRA) || (instr.op == cu_isa_pkg::OP_RRC);
	assign alu_idx = is_shift ? 5'(instr.op - cu_isa_pkg::OP_ADD - 7'd2)
		: 5'(instr.op - cu_isa_pkg::OP_ADD);
	assign dst_rnum = {2'b00, instr.dst};
	assign src_rnum = {2'b00, instr.srccon};
	assign src_rc_rnum = {1'b0, instr.rc, instr.srccon};	// Constants sit at 8 to 15

	assign cex_load.result = taken;
	assign cex_load.t_cnt = instr.t_cnt;
	assign cex_load.f_cnt = instr.f_cnt;

	always_comb
	begin
		step_done = 1'b0;
		cex_load.load = 1'b0;
		data_bus_ctrl = cu_ctrl_pkg::BUS_IDLE;
		addr_bus_ctrl = cu_ctrl_pkg::BUS_IDLE;
		psw_bus_ctrl = cu_ctrl_pkg::PSW_SEL_IDLE;
		psw_update = 1'b0;
		alu_op = cu_ctrl_pkg::ALU_OP_ADD;
		dbus_rnum_dst = cu_isa_pkg::RNUM_PC;
		dbus_rnum_src = cu_isa_pkg::RNUM_PC;
		alu_rnum_dst = cu_isa_pkg::RNUM_PC;
		alu_rnum_src = cu_isa_pkg::RNUM_CONST2;
		addr_rnum_src = cu_isa_pkg::RNUM_PC;
		s_bus_ctrl = 1'b0;	// Register file on S-bus
		sxt_bus_ctrl = 1'b0;
		sxt_shift = 1'b0;
		sxt_bit_num = 5'd0;
		case (state)
			cu_ctrl_pkg::CYC_FETCH:
				addr_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_MDR};	// PC to MAR
			cu_ctrl_pkg::CYC_PC_WB:
				data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_ALU, cu_ctrl_pkg::DST_REG};	// PC + 2 back
			cu_ctrl_pkg::CYC_IR_LOAD:
				data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_MDR, cu_ctrl_pkg::DST_IR};
			cu_ctrl_pkg::CYC_EXEC1:
			begin
				step_done = (instr.op != cu_isa_pkg::OP_SWAP);	// Only SWAP runs on
				case (instr.op) inside
					[cu_isa_pkg::OP_ADD:cu_isa_pkg::OP_BIS], cu_isa_pkg::OP_SRA,
					cu_isa_pkg::OP_RRC:
					begin
						psw_bus_ctrl = cu_ctrl_pkg::PSW_SEL_ALU;
						psw_update = 1'b1;
						alu_op = {alu_idx, instr.wb};
						alu_rnum_dst = dst_rnum;
						alu_rnum_src = src_rc_rnum;
						dbus_rnum_dst = dst_rnum;
						data_bus_ctrl = {instr.wb, cu_ctrl_pkg::SRC_ALU, cu_ctrl_pkg::DST_REG};
					end
					cu_isa_pkg::OP_MOV:
					begin
						dbus_rnum_src = src_rnum;
						dbus_rnum_dst = dst_rnum;
						data_bus_ctrl = {instr.wb, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG};
					end
					cu_isa_pkg::OP_SWAP:
					begin
						dbus_rnum_src = src_rnum;	// Park source in TEMP
						dbus_rnum_dst = cu_isa_pkg::RNUM_TEMP;
						data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG};
					end
					[cu_isa_pkg::OP_BEQ:cu_isa_pkg::OP_BRA]:
					begin
						if (taken)
						begin
							s_bus_ctrl = 1'b1;	// Offset from sign extender
							sxt_bus_ctrl = 1'b1;
							sxt_shift = 1'b1;	// Word offset
							sxt_bit_num = cu_isa_pkg::SXT_BIT_BRANCH;
							data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_ALU, cu_ctrl_pkg::DST_REG};
						end
					end
					cu_isa_pkg::OP_CEX: cex_load.load = 1'b1;
					default: step_done = 1'b1;	// SETCC, CLRCC in PSW register
				endcase
			end
			cu_ctrl_pkg::CYC_EXEC2:
			begin
				step_done = (instr.op != cu_isa_pkg::OP_SWAP);
				dbus_rnum_src = dst_rnum;	// dst into src
				dbus_rnum_dst = src_rnum;
				if (instr.op == cu_isa_pkg::OP_SWAP)
					data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG};
			end
			cu_ctrl_pkg::CYC_EXEC3:
			begin
				step_done = 1'b1;
				dbus_rnum_src = cu_isa_pkg::RNUM_TEMP;	// TEMP into dst
				dbus_rnum_dst = dst_rnum;
				if (instr.op == cu_isa_pkg::OP_SWAP)
					data_bus_ctrl = {1'b0, cu_ctrl_pkg::SRC_REG, cu_ctrl_pkg::DST_REG};
			end
			default: step_done = 1'b0;	// HALT and DECODE drive nothing
		endcase
	end

	always_comb
	begin
		flags_nxt = psw_in[4:0];
		if (state == cu_ctrl_pkg::CYC_EXEC1)
		begin
			if (instr.op == cu_isa_pkg::OP_SETCC)
				flags_nxt = psw_in[4:0] | instr.pswb;
			else if (instr.op == cu_isa_pkg::OP_CLRCC)
				flags_nxt = psw_in[4:0] & ~instr.pswb;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw_out <= '0;
		else
			psw_out <= {psw_in[15:5], flags_nxt};	// Follows psw_in one cycle late
	end

	// SWAP walks through EXEC2 and ends only in EXEC3
	a_swap_steps: assert property (@(posedge clock) disable iff (cpucycle_rst)
		((state == cu_ctrl_pkg::CYC_EXEC1) && (instr.op == cu_isa_pkg::OP_SWAP))
		|=> ((state == cu_ctrl_pkg::CYC_EXEC2) && !step_done)
		##1 ((state == cu_ctrl_pkg::CYC_EXEC3) && step_done));

endmodule

`default_nettype wire

// ==== cond_eval.sv ====
`timescale 1ns/10ps
`default_nettype none

module cond_eval
(
	input cu_isa_pkg::cond_t cond,
	input cu_isa_pkg::flag_bits_t flags,
	output logic taken
);

	logic flag_c;
	logic flag_z;
	logic flag_n;
	logic flag_v;

	assign flag_c = flags[cu_isa_pkg::PSW_C];
	assign flag_z = flags[cu_isa_pkg::PSW_Z];
	assign flag_n = flags[cu_isa_pkg::PSW_N];
	assign flag_v = flags[cu_isa_pkg::PSW_V];

	always_comb
	begin
		case (cond)
			cu_isa_pkg::COND_EQ: taken = flag_z;
			cu_isa_pkg::COND_NE: taken = !flag_z;
			cu_isa_pkg::COND_CS: taken = flag_c;
			cu_isa_pkg::COND_CC: taken = !flag_c;
			cu_isa_pkg::COND_MI: taken = flag_n;
			cu_isa_pkg::COND_PL: taken = !flag_n;
			cu_isa_pkg::COND_VS: taken = flag_v;
			cu_isa_pkg::COND_VC: taken = !flag_v;
			cu_isa_pkg::COND_HI: taken = flag_c && !flag_z;	// Unsigned higher
			cu_isa_pkg::COND_LS: taken = !flag_c || flag_z;
			cu_isa_pkg::COND_GE: taken = (flag_n == flag_v);	// Signed compares
			cu_isa_pkg::COND_LT: taken = (flag_n != flag_v);
			cu_isa_pkg::COND_GT: taken = !flag_z && (flag_n == flag_v);
			cu_isa_pkg::COND_LE: taken = flag_z || (flag_n != flag_v);
			cu_isa_pkg::COND_AL: taken = 1'b1;
			default: taken = 1'b0;	// Code 15 never holds
		endcase
	end

endmodule

`default_nettype wire

// ==== cex_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cex_tracker
(
	input logic clock,
	input logic cpucycle_rst,
	input cu_ctrl_pkg::cycle_state_t state,
	cex_load_if.dst_mp cex_load,
	output logic decode_allow,
	output logic [7:0] cex_state
);

	logic active;	// CEX block in progress
	logic result;	// Condition outcome at load
	cu_isa_pkg::cex_cnt_t t_cnt;
	cu_isa_pkg::cex_cnt_t f_cnt;
	cu_isa_pkg::cex_cnt_t t_nxt;
	cu_isa_pkg::cex_cnt_t f_nxt;
	logic t_dec;

	assign cex_state = {active, result, t_cnt, f_cnt};

	// True instructions run first, false ones only once the true count is spent
	assign decode_allow = !active || (result && (t_cnt != 3'd0))
		|| (!result && (t_cnt == 3'd0) && (f_cnt != 3'd0));

	assign t_dec = (t_cnt != 3'd0);
	assign t_nxt = t_dec ? t_cnt - 3'd1 : t_cnt;
	assign f_nxt = (!t_dec && (f_cnt != 3'd0)) ? f_cnt - 3'd1 : f_cnt;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			t_cnt <= 3'd0;
			f_cnt <= 3'd0;
		end
		else if (cex_load.load)
		begin
			active <= 1'b1;
			result <= cex_load.result;
			t_cnt <= cex_load.t_cnt;
			f_cnt <= cex_load.f_cnt;
		end
		else if ((state == cu_ctrl_pkg::CYC_DECODE) && active)
		begin
			t_cnt <= t_nxt;
			f_cnt <= f_nxt;
			active <= (t_nxt != 3'd0) || (f_nxt != 3'd0);	// Block ends when both spent
		end
	end

	// Between loads the counts only fall, so neither wraps below zero
	a_no_underflow: assert property (@(posedge clock) disable iff (cpucycle_rst)
		!cex_load.load |=> ((t_cnt <= $past(t_cnt)) && (f_cnt <= $past(f_cnt))));

endmodule

`default_nettype wire

// ==== cycle_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cycle_sequencer
(
	input logic clock,
	input logic cpucycle_rst,
	input cu_isa_pkg::word_t pc,
	input cu_isa_pkg::word_t brkpnt,
	input cu_isa_pkg::word_t psw_in,
	input logic step_done,
	input logic decode_allow,
	output cu_ctrl_pkg::cycle_state_t state,
	output logic id_en
);

	cu_ctrl_pkg::cycle_state_t state_nxt;
	cu_ctrl_pkg::cycle_state_t end_state;	// Where an ending instruction goes
	logic halt_cause;

	assign halt_cause = (pc == brkpnt) || psw_in[cu_isa_pkg::PSW_SLP];	// Breakpoint or sleep
	assign end_state = halt_cause ? cu_ctrl_pkg::CYC_HALT : cu_ctrl_pkg::CYC_FETCH;
	assign id_en = (state == cu_ctrl_pkg::CYC_DECODE) && decode_allow;

	always_comb
	begin
		state_nxt = end_state;	// HALT and EXEC3 leave the same way
		case (state)
			cu_ctrl_pkg::CYC_FETCH: state_nxt = cu_ctrl_pkg::CYC_PC_WB;
			cu_ctrl_pkg::CYC_PC_WB: state_nxt = cu_ctrl_pkg::CYC_IR_LOAD;
			cu_ctrl_pkg::CYC_IR_LOAD: state_nxt = cu_ctrl_pkg::CYC_DECODE;
			cu_ctrl_pkg::CYC_DECODE:
			begin
				if (decode_allow)
					state_nxt = cu_ctrl_pkg::CYC_EXEC1;	// Else skipped by CEX
			end
			cu_ctrl_pkg::CYC_EXEC1:
			begin
				if (!step_done)
					state_nxt = cu_ctrl_pkg::CYC_EXEC2;
			end
			cu_ctrl_pkg::CYC_EXEC2:
			begin
				if (!step_done)
					state_nxt = cu_ctrl_pkg::CYC_EXEC3;
			end
			default: state_nxt = end_state;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			state <= cu_ctrl_pkg::CYC_HALT;
		else
			state <= state_nxt;
	end

	// States past FETCH are entered only from the one just before
	a_state_legal: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(state inside {[cu_ctrl_pkg::CYC_PC_WB:cu_ctrl_pkg::CYC_EXEC3]})
		|-> ($past(state) == state - 3'd1));

endmodule

`default_nettype wire

// ==== cu_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

interface instr_if;
	cu_isa_pkg::opcode_t op;
	cu_isa_pkg::reg_sel_t dst;
	cu_isa_pkg::reg_sel_t srccon;	// Source register or constant index
	logic rc;	// Selects the constant bank
	logic wb;	// Byte when set
	cu_isa_pkg::cond_t cond;
	cu_isa_pkg::cex_cnt_t t_cnt;
	cu_isa_pkg::cex_cnt_t f_cnt;
	cu_isa_pkg::flag_bits_t pswb;

	modport exec_mp (input op, dst, srccon, rc, wb, cond, t_cnt, f_cnt, pswb);
endinterface

interface cex_load_if;
	logic load;	// One cycle strobe in EXEC1 of CEX
	logic result;
	cu_isa_pkg::cex_cnt_t t_cnt;
	cu_isa_pkg::cex_cnt_t f_cnt;

	modport src_mp (output load, result, t_cnt, f_cnt);
	modport dst_mp (input load, result, t_cnt, f_cnt);
endinterface

`default_nettype wire

// ==== cu_ctrl_pkg.sv ====
`default_nettype none

package cu_ctrl_pkg;

	// Value equals the cycle number shown to the rest of the processor
	typedef enum logic [2:0]
	{
		CYC_HALT = 3'd0,
		CYC_FETCH = 3'd1,
		CYC_PC_WB = 3'd2,
		CYC_IR_LOAD = 3'd3,
		CYC_DECODE = 3'd4,
		CYC_EXEC1 = 3'd5,
		CYC_EXEC2 = 3'd6,
		CYC_EXEC3 = 3'd7
	} cycle_state_t;

	typedef logic [6:0] bus_ctrl_t;	// {byte/word, source, destination}
	typedef logic [1:0] psw_sel_t;	// PSW load source
	typedef logic [5:0] alu_op_t;	// {operation, byte/word}

	localparam logic [2:0] SRC_MDR = 3'd0;
	localparam logic [2:0] SRC_REG = 3'd1;	// Register file
	localparam logic [2:0] SRC_ALU = 3'd3;

	localparam logic [2:0] DST_MDR = 3'd0;	// MAR when on the address bus
	localparam logic [2:0] DST_REG = 3'd1;
	localparam logic [2:0] DST_IR = 3'd2;

	localparam bus_ctrl_t BUS_IDLE = 7'h7f;	// No source drives, nothing loads

	localparam psw_sel_t PSW_SEL_ALU = 2'd0;
	localparam psw_sel_t PSW_SEL_IDLE = 2'd3;

	localparam alu_op_t ALU_OP_ADD = 6'd0;	// Word add

endpackage

`default_nettype wire

// ==== cu_isa_pkg.sv ====
`default_nettype none

package cu_isa_pkg;

	typedef logic [15:0] word_t;	// PC, breakpoint and PSW width
	typedef logic [6:0] opcode_t;	// Decoded instruction number
	typedef logic [2:0] reg_sel_t;	// Register field of the instruction
	typedef logic [4:0] rnum_t;	// Register file address, bit 4 picks TEMP
	typedef logic [3:0] cond_t;	// Condition code
	typedef logic [2:0] cex_cnt_t;	// CEX true or false count
	typedef logic [4:0] flag_bits_t;	// PSW flag field

	// Branches, in condition evaluator order except BGE and BLT
	localparam opcode_t OP_BEQ = 7'd1;
	localparam opcode_t OP_BNE = 7'd2;
	localparam opcode_t OP_BC = 7'd3;
	localparam opcode_t OP_BNC = 7'd4;
	localparam opcode_t OP_BN = 7'd5;
	localparam opcode_t OP_BGE = 7'd6;
	localparam opcode_t OP_BLT = 7'd7;
	localparam opcode_t OP_BRA = 7'd8;
	localparam opcode_t OP_ADD = 7'd9;	// First register ALU op
	localparam opcode_t OP_BIS = 7'd20;	// Last of the contiguous ALU ops
	localparam opcode_t OP_MOV = 7'd21;
	localparam opcode_t OP_SWAP = 7'd22;
	localparam opcode_t OP_SRA = 7'd23;
	localparam opcode_t OP_RRC = 7'd24;
	localparam opcode_t OP_SETCC = 7'd30;
	localparam opcode_t OP_CLRCC = 7'd31;
	localparam opcode_t OP_CEX = 7'd32;

	localparam cond_t COND_EQ = 4'd0;	// Z set
	localparam cond_t COND_NE = 4'd1;	// Z clear
	localparam cond_t COND_CS = 4'd2;	// Carry set, also HS
	localparam cond_t COND_CC = 4'd3;	// Carry clear, also LO
	localparam cond_t COND_MI = 4'd4;
	localparam cond_t COND_PL = 4'd5;
	localparam cond_t COND_VS = 4'd6;
	localparam cond_t COND_VC = 4'd7;
	localparam cond_t COND_HI = 4'd8;	// C set and Z clear
	localparam cond_t COND_LS = 4'd9;	// C clear or Z set
	localparam cond_t COND_GE = 4'd10;
	localparam cond_t COND_LT = 4'd11;
	localparam cond_t COND_GT = 4'd12;
	localparam cond_t COND_LE = 4'd13;
	localparam cond_t COND_AL = 4'd14;

	localparam int PSW_C = 0;
	localparam int PSW_Z = 1;
	localparam int PSW_N = 2;
	localparam int PSW_SLP = 3;	// Sleep, halts the sequencer
	localparam int PSW_V = 4;

	localparam rnum_t RNUM_PC = 5'd7;
	localparam rnum_t RNUM_CONST2 = 5'd10;	// Constant register holding 2
	localparam rnum_t RNUM_TEMP = 5'd16;
	localparam logic [4:0] SXT_BIT_BRANCH = 5'd10;	// Sign bit of branch offset

endpackage

`default_nettype wire
